//--- Makefile
VERILATOR := verilator
TOP       := cast_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a $fatal in the testbench gives a non-zero exit status
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+verification
hdl/cast_pkg.sv
hdl/ram_block.sv
hdl/bram2hs_cast.sv
hdl/batch_reducer.sv
hdl/result_port.sv
hdl/cast_top.sv
verification/cast_tb.sv

//--- hdl/batch_reducer.sv
`timescale 1ns/1ps

module batch_reducer #(
  parameter int OUT_SIZE  = 8,
  parameter int OUT_WIDTH = 8
) (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic [OUT_WIDTH-1:0]                              data_out [OUT_SIZE-1:0],
  input  logic [$clog2(OUT_SIZE+1)-1:0]                     data_out_count,
  input  logic                                              data_out_valid,
  output logic                                              data_out_ready,
  output logic [cast_pkg::sum_width(OUT_WIDTH, OUT_SIZE)-1:0] sum_value,
  output logic [OUT_WIDTH-1:0]                              max_value,
  output logic                                              sum_valid,
  input  logic                                              sum_ready
);
  import cast_pkg::*;

  localparam int SUM_WIDTH = sum_width(OUT_WIDTH, OUT_SIZE);
  localparam int COUNT_WIDTH = $clog2(OUT_SIZE + 1);

  logic [SUM_WIDTH-1:0] batch_sum;
  logic [OUT_WIDTH-1:0] batch_max;
  logic                 take;

  // only the first data_out_count entries belong to the batch
  always_comb begin
    batch_sum = '0;
    batch_max = '0;
    for (int i = 0; i < OUT_SIZE; i++) begin
      if (COUNT_WIDTH'(i) < data_out_count) begin
        batch_sum = batch_sum + SUM_WIDTH'(data_out[i]);
        if (data_out[i] > batch_max) batch_max = data_out[i];
      end
    end
  end

  // accept when the output slot is free or drains this cycle
  assign data_out_ready = !sum_valid || sum_ready;
  assign take = data_out_valid && data_out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_valid <= 1'b0;
    end else if (take) begin
      sum_valid <= 1'b1;
    end else if (sum_ready) begin
      sum_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sum_value <= batch_sum;
      max_value <= batch_max;
    end
  end

  // an empty or oversized batch means the cast counters went wrong
  a_count_legal: assert property (@(posedge clk) disable iff (rst)
    data_out_valid |->
      (data_out_count != '0) && (data_out_count <= COUNT_WIDTH'(OUT_SIZE)));

endmodule

//--- hdl/bram2hs_cast.sv
`timescale 1ns/1ps

module bram2hs_cast #(
  parameter int OUT_SIZE   = 8,
  parameter int OUT_WIDTH  = 8,
  parameter int ADDR_RANGE = 100,
  parameter int ADDR_WIDTH = 7
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [ADDR_WIDTH-1:0]          address0,
  input  logic                           ce0,
  input  logic                           we0,
  input  logic [OUT_WIDTH-1:0]           d0,
  output logic [OUT_WIDTH-1:0]           data_out [OUT_SIZE-1:0],
  output logic [$clog2(OUT_SIZE+1)-1:0]  data_out_count,
  output logic                           data_out_valid,
  input  logic                           data_out_ready,
  input  logic                           in_done,
  output logic                           in_ce
);
  import cast_pkg::*;

  localparam int COUNT_WIDTH = $clog2(OUT_SIZE + 1);
  localparam int FRAME_BITS = ADDR_WIDTH + 1;
  localparam logic [COUNT_WIDTH-1:0] BATCH_FULL = COUNT_WIDTH'(OUT_SIZE);
  localparam logic [FRAME_BITS-1:0] FRAME_LEN = FRAME_BITS'(ADDR_RANGE);

  cast_state_t state;

  // one bit wider than the address so the frame length itself fits
  logic [FRAME_BITS-1:0]  frame_pos;
  logic [COUNT_WIDTH-1:0] issue_cnt;
  logic [COUNT_WIDTH-1:0] data_cnt;
  logic                   rd_pending;
  logic                   issuing;
  logic                   frame_left;
  logic [ADDR_WIDTH-1:0]  address1;
  logic [OUT_WIDTH-1:0]   q1;
  logic [OUT_WIDTH-1:0]   batch_buf [OUT_SIZE-1:0];

  assign frame_left = (frame_pos != FRAME_LEN);
  // a read is issued while the batch has room and the frame has words
  assign issuing = (state == cast_fill) && (issue_cnt != BATCH_FULL) && frame_left;
  assign address1 = frame_pos[ADDR_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= cast_idle;
      frame_pos  <= '0;
      issue_cnt  <= '0;
      data_cnt   <= '0;
      rd_pending <= 1'b0;
    end else begin
      // q1 lags the address by one cycle
      rd_pending <= issuing;
      if (issuing) begin
        frame_pos <= frame_pos + 1'b1;
        issue_cnt <= issue_cnt + 1'b1;
      end
      if (rd_pending) data_cnt <= data_cnt + 1'b1;

      case (state)
        cast_idle: begin
          frame_pos <= '0;
          if (in_done) state <= cast_fill;
        end
        cast_fill: begin
          // last word lands on this edge
          if (rd_pending && !issuing) state <= cast_hold;
        end
        cast_hold: begin
          if (data_out_ready) begin
            issue_cnt <= '0;
            data_cnt  <= '0;
            state     <= frame_left ? cast_fill : cast_idle;
          end
        end
        default: state <= cast_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pending) batch_buf[int'(data_cnt)] <= q1;
  end

  assign data_out       = batch_buf;
  assign data_out_count = data_cnt;
  assign data_out_valid = (state == cast_hold);
  assign in_ce          = (state == cast_idle);

  // port 1 is read only
  ram_block #(
    .DWIDTH  (OUT_WIDTH),
    .AWIDTH  (ADDR_WIDTH),
    .MEM_SIZE(ADDR_RANGE)
  ) data_ram (
    .clk  (clk),
    .addr0(address0),
    .ce0  (ce0),
    .we0  (we0),
    .d0   (d0),
    .q0   (),
    .addr1(address1),
    .ce1  (1'b1),
    .we1  (1'b0),
    .d1   ('0),
    .q1   (q1)
  );

  // every issued read has landed, and only the tail of a frame may be short
  a_batch_count: assert property (@(posedge clk) disable iff (rst)
    data_out_valid |-> (data_cnt == issue_cnt) &&
      (frame_left ? (data_cnt == BATCH_FULL) : (data_cnt != '0)));

  a_done_in_idle: assert property (@(posedge clk) disable iff (rst)
    in_done |-> (state == cast_idle));

endmodule

//--- hdl/cast_pkg.sv
package cast_pkg;

  // state of the frame to batch converter
  typedef enum logic [1:0] {
    cast_idle = 2'd0,  // waiting for the producer to finish a frame
    cast_fill = 2'd1,  // reading words of the current batch
    cast_hold = 2'd2   // batch complete and offered downstream
  } cast_state_t;

  // width of a batch sum
  // a full batch of all-ones words must still fit
  function automatic int sum_width(input int out_width, input int out_size);
    return out_width + $clog2(out_size) + 1;
  endfunction

endpackage

//--- hdl/cast_top.sv
`timescale 1ns/1ps

module cast_top #(
  parameter int OUT_SIZE   = 8,
  parameter int OUT_WIDTH  = 8,
  parameter int ADDR_RANGE = 100,
  parameter int ADDR_WIDTH = 7
) (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic [ADDR_WIDTH-1:0]                             address0,
  input  logic                                              ce0,
  input  logic                                              we0,
  input  logic [OUT_WIDTH-1:0]                              d0,
  input  logic                                              in_done,
  output logic                                              in_ce,
  output logic                                              res_req,
  output logic [cast_pkg::sum_width(OUT_WIDTH, OUT_SIZE)-1:0] res_sum,
  output logic [OUT_WIDTH-1:0]                              res_max,
  input  logic                                              res_ack
);
  import cast_pkg::*;

  localparam int SUM_WIDTH = sum_width(OUT_WIDTH, OUT_SIZE);
  localparam int COUNT_WIDTH = $clog2(OUT_SIZE + 1);

  logic [OUT_WIDTH-1:0]   data_out [OUT_SIZE-1:0];
  logic [COUNT_WIDTH-1:0] data_out_count;
  logic                   data_out_valid;
  logic                   data_out_ready;
  logic [SUM_WIDTH-1:0]   sum_value;
  logic [OUT_WIDTH-1:0]   max_value;
  logic                   sum_valid;
  logic                   sum_ready;

  // decode, frame into batches
  bram2hs_cast #(
    .OUT_SIZE  (OUT_SIZE),
    .OUT_WIDTH (OUT_WIDTH),
    .ADDR_RANGE(ADDR_RANGE),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_cast (
    .clk           (clk),
    .rst           (rst),
    .address0      (address0),
    .ce0           (ce0),
    .we0           (we0),
    .d0            (d0),
    .data_out      (data_out),
    .data_out_count(data_out_count),
    .data_out_valid(data_out_valid),
    .data_out_ready(data_out_ready),
    .in_done       (in_done),
    .in_ce         (in_ce)
  );

  // execute, sum and max per batch
  batch_reducer #(
    .OUT_SIZE (OUT_SIZE),
    .OUT_WIDTH(OUT_WIDTH)
  ) u_reducer (
    .clk           (clk),
    .rst           (rst),
    .data_out      (data_out),
    .data_out_count(data_out_count),
    .data_out_valid(data_out_valid),
    .data_out_ready(data_out_ready),
    .sum_value     (sum_value),
    .max_value     (max_value),
    .sum_valid     (sum_valid),
    .sum_ready     (sum_ready)
  );

  // result, four-phase delivery
  result_port #(
    .OUT_SIZE (OUT_SIZE),
    .OUT_WIDTH(OUT_WIDTH)
  ) u_result (
    .clk      (clk),
    .rst      (rst),
    .sum_value(sum_value),
    .max_value(max_value),
    .sum_valid(sum_valid),
    .sum_ready(sum_ready),
    .res_req  (res_req),
    .res_sum  (res_sum),
    .res_max  (res_max),
    .res_ack  (res_ack)
  );

endmodule

//--- hdl/ram_block.sv
`timescale 1ns/1ps

module ram_block #(
  parameter int DWIDTH   = 8,
  parameter int AWIDTH   = 7,
  parameter int MEM_SIZE = 100
) (
  input  logic              clk,
  input  logic [AWIDTH-1:0] addr0,
  input  logic              ce0,
  input  logic              we0,
  input  logic [DWIDTH-1:0] d0,
  output logic [DWIDTH-1:0] q0,
  input  logic [AWIDTH-1:0] addr1,
  input  logic              ce1,
  input  logic              we1,
  input  logic [DWIDTH-1:0] d1,
  output logic [DWIDTH-1:0] q1
);

  logic [DWIDTH-1:0] mem [MEM_SIZE];

  // both ports read synchronously, port 1 wins on a same-address write
  always_ff @(posedge clk) begin
    if (ce0) begin
      if (we0) mem[addr0] <= d0;
      q0 <= mem[addr0];
    end
    if (ce1) begin
      if (we1) mem[addr1] <= d1;
      q1 <= mem[addr1];
    end
  end

  // writes outside the frame storage would be silently dropped
  a_write_in_range: assert property (@(posedge clk)
    ((ce0 && we0) |-> (int'(addr0) < MEM_SIZE)) and
    ((ce1 && we1) |-> (int'(addr1) < MEM_SIZE)));

endmodule

//--- hdl/result_port.sv
`timescale 1ns/1ps

module result_port #(
  parameter int OUT_SIZE  = 8,
  parameter int OUT_WIDTH = 8
) (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic [cast_pkg::sum_width(OUT_WIDTH, OUT_SIZE)-1:0] sum_value,
  input  logic [OUT_WIDTH-1:0]                              max_value,
  input  logic                                              sum_valid,
  output logic                                              sum_ready,
  output logic                                              res_req,
  output logic [cast_pkg::sum_width(OUT_WIDTH, OUT_SIZE)-1:0] res_sum,
  output logic [OUT_WIDTH-1:0]                              res_max,
  input  logic                                              res_ack
);

  // handshake phases
  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_REQ  = 2'd1;
  localparam logic [1:0] PH_DROP = 2'd2;

  logic [1:0] phase;

  // a new summary is taken only once the previous round trip is closed
  assign sum_ready = (phase == PH_IDLE);
  assign res_req   = (phase == PH_REQ);

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_IDLE;
    end else begin
      case (phase)
        PH_IDLE: if (sum_valid) phase <= PH_REQ;
        PH_REQ:  if (res_ack) phase <= PH_DROP;
        // req is low here, wait for the far side to release ack
        PH_DROP: if (!res_ack) phase <= PH_IDLE;
        default: phase <= PH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid && sum_ready) begin
      res_sum <= sum_value;
      res_max <= max_value;
    end
  end

  // ack rises only against a raised req and falls only once req is low
  a_ack_order: assert property (@(posedge clk) disable iff (rst)
    ($rose(res_ack) |-> res_req) and ($fell(res_ack) |-> !res_req));

endmodule

//--- verification/cast_model.svh
`ifndef CAST_MODEL_SVH
`define CAST_MODEL_SVH

// expected summaries in the order batches leave the frame
// one entry per batch, sum and max kept in step
logic [SUM_WIDTH-1:0] exp_sum [$];
logic [OUT_WIDTH-1:0] exp_max [$];

// cut frame_words into batches of OUT_SIZE words, the last one may be short
function automatic int model_frame();
  int base;
  int n;
  int batches;
  logic [SUM_WIDTH-1:0] s;
  logic [OUT_WIDTH-1:0] m;
  base = 0;
  batches = 0;
  while (base < ADDR_RANGE) begin
    n = (ADDR_RANGE - base < OUT_SIZE) ? (ADDR_RANGE - base) : OUT_SIZE;
    s = '0;
    m = '0;
    for (int i = 0; i < n; i++) begin
      s = s + SUM_WIDTH'(frame_words[base + i]);
      if (frame_words[base + i] > m) m = frame_words[base + i];
    end
    exp_sum.push_back(s);
    exp_max.push_back(m);
    batches++;
    base += n;
  end
  return batches;
endfunction

`endif

//--- verification/cast_tb.sv
`timescale 1ns/1ps

module cast_tb;

  localparam int OUT_SIZE   = 8;
  localparam int OUT_WIDTH  = 8;
  localparam int ADDR_RANGE = 100;
  localparam int ADDR_WIDTH = 7;
  localparam int SUM_WIDTH  = cast_pkg::sum_width(OUT_WIDTH, OUT_SIZE);
  localparam int NUM_FRAMES = 6;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * ADDR_RANGE * 40;
  localparam logic [31:0] SEED = 32'hc8cc_bb3b;

  logic                  clk;
  logic                  rst;
  logic [ADDR_WIDTH-1:0] address0;
  logic                  ce0;
  logic                  we0;
  logic [OUT_WIDTH-1:0]  d0;
  logic                  in_done;
  logic                  in_ce;
  logic                  res_req;
  logic [SUM_WIDTH-1:0]  res_sum;
  logic [OUT_WIDTH-1:0]  res_max;
  logic                  res_ack;

  logic [OUT_WIDTH-1:0]  frame_words [ADDR_RANGE];
  int                    ack_max_delay;

  `include "cast_model.svh"

  cast_top #(
    .OUT_SIZE  (OUT_SIZE),
    .OUT_WIDTH (OUT_WIDTH),
    .ADDR_RANGE(ADDR_RANGE),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) DUT (
    .clk     (clk),
    .rst     (rst),
    .address0(address0),
    .ce0     (ce0),
    .we0     (we0),
    .d0      (d0),
    .in_done (in_done),
    .in_ce   (in_ce),
    .res_req (res_req),
    .res_sum (res_sum),
    .res_max (res_max),
    .res_ack (res_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check_value(input string what, input longint got, input longint expected);
    if (got != expected) begin
      fail_run($sformatf("mismatch at %0t: %s, got %0d, expected %0d",
                         $time, what, got, expected));
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic drive_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic send_frame(input bit all_max);
    int idle;
    drive_edge();
    while (!in_ce) drive_edge();
    // at most the last batch in the reducer and one summary requested on this edge
    check_value("summaries in flight when in_ce rises",
                longint'(exp_sum.size() <= 2), 1);
    for (int a = 0; a < ADDR_RANGE; a++) begin
      frame_words[a] = all_max ? '1 : OUT_WIDTH'($urandom);
    end
    void'(model_frame());
    for (int a = 0; a < ADDR_RANGE; a++) begin
      if ($urandom_range(3, 0) == 0) begin
        idle = $urandom_range(3, 1);
        repeat (idle) begin
          drive_edge();
          ce0 = 1'b0;
          we0 = 1'b0;
        end
      end
      drive_edge();
      address0 = ADDR_WIDTH'(a);
      ce0      = 1'b1;
      we0      = 1'b1;
      d0       = frame_words[a];
    end
    drive_edge();
    ce0     = 1'b0;
    we0     = 1'b0;
    in_done = 1'b1;
    drive_edge();
    in_done = 1'b0;
  endtask

  // four-phase partner on the result side
  initial begin : ack_responder
    int delay;
    res_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst && res_req) begin
        delay = $urandom_range(ack_max_delay, 0);
        repeat (delay) @(posedge clk);
        drive_edge();
        res_ack = 1'b1;
        @(negedge clk);
        while (res_req) @(negedge clk);
        delay = $urandom_range(ack_max_delay, 0);
        repeat (delay) @(posedge clk);
        drive_edge();
        res_ack = 1'b0;
      end
    end
  end

  // each rising res_req carries one new summary
  initial begin : summary_monitor
    logic req_seen;
    req_seen = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst && res_req && !req_seen) begin
        check_value("res_ack low when res_req rises", longint'(res_ack), 0);
        if (exp_sum.size() == 0) begin
          fail_run("a summary arrived when none was expected");
        end else begin
          check_value("res_sum", longint'(res_sum), longint'(exp_sum.pop_front()));
          check_value("res_max", longint'(res_max), longint'(exp_max.pop_front()));
        end
      end
      req_seen = res_req;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("timeout, the summaries did not all arrive within the cycle limit");
  end

  initial begin : main_sequence
    void'($urandom(SEED));
    rst           = 1'b1;
    address0      = '0;
    ce0           = 1'b0;
    we0           = 1'b0;
    d0            = '0;
    in_done       = 1'b0;
    ack_max_delay = 6;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    check_value("res_req after reset", longint'(res_req), 0);
    check_value("in_ce after reset", longint'(in_ce), 1);

    // frames 3 and 4 hold ack long enough to back up the pipeline
    for (int f = 0; f < NUM_FRAMES; f++) begin
      ack_max_delay = (f == 3 || f == 4) ? 25 : 6;
      send_frame(f == 2);
    end

    while (exp_sum.size() != 0) @(negedge clk);
    // late extra summaries would still hit the monitor here
    repeat (200) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule
